// File: Makefile
SIM := obj_dir/Vtb_accum_engine

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): src.f $(shell cat src.f)
	verilator --binary --timing --timescale 1ns/1ps -j 0 \
	  --top-module tb_accum_engine -f src.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	  echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

// File: dv/tb_accum_engine.sv
// ##########################################################
// Testbench of the stream accumulator engine
// Xorshift stimulus driven on the falling edge
// Queue model of accepted words and expected block sums
// Value check task, drain loops with timeouts
// ##########################################################

module tb_accum_engine
  import hwpe_stream_package::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  logic  clk;
  logic  rst_n;
  logic  clear_i;
  len_t  len_i;
  data_t in_data_i;
  strb_t in_strb_i;
  logic  in_valid_i;
  logic  in_ready_o;
  data_t out_data_o;
  strb_t out_strb_o;
  logic  out_valid_o;
  logic  out_ready_i;
  logic  in_empty_o;
  logic  in_full_o;
  logic  out_empty_o;
  logic  out_full_o;

  logic [31:0] rng_state = 32'h7ab2_754a;

  // Stimulus state
  int    cur_len    = 1;     // Words per block of the running group
  int    beats_left = 0;     // Words still to be offered
  logic  pend_valid = 1'b0;  // Beat offered but not yet taken
  data_t pend_data  = '0;
  strb_t pend_strb  = '0;

  // Reference model
  data_t acc_q[$];  // Masked words of the open block
  data_t exp_q[$];  // Block sums not yet seen at the output

  tb_clock_gen i_clock_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  accum_engine_top dut (
    .clk_i       ( clk         ),
    .rst_ni      ( rst_n       ),
    .clear_i     ( clear_i     ),
    .len_i       ( len_i       ),
    .in_data_i   ( in_data_i   ),
    .in_strb_i   ( in_strb_i   ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .out_data_o  ( out_data_o  ),
    .out_strb_o  ( out_strb_o  ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .in_empty_o  ( in_empty_o  ),
    .in_full_o   ( in_full_o   ),
    .out_empty_o ( out_empty_o ),
    .out_full_o  ( out_full_o  )
  );

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic int pct();
    return int'(next_rand() % 32'd100);  // 0 to 99
  endfunction

  // Bytes with a low strobe count as zero
  function automatic data_t mask_bytes(input data_t d, input strb_t s);
    data_t keep;
    keep = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    return d & keep;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1, "Simulation stopped on a failed check");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      report_failure("Value mismatch on a DUT output");
    end
  endtask

  // One accepted word enters the model
  task automatic model_accept(input data_t d, input strb_t s);
    data_t sum;
    acc_q.push_back(mask_bytes(d, s));
    if (acc_q.size() == cur_len) begin
      sum = '0;
      foreach (acc_q[i]) sum += acc_q[i];  // Wraps at 32 bits
      exp_q.push_back(sum);
      acc_q.delete();
    end
  endtask

  // One clock cycle with outputs sampled and inputs driven at the falling edge
  task automatic do_cycle(input int gap_pct, input int bp_pct);
    data_t exp_sum;
    @(negedge clk);
    // Outputs come from registers and are settled here
    if (in_full_o) check_value("in_ready_o", 32'(in_ready_o), 32'h0);
    if (!out_valid_o) check_value("out_data_o", out_data_o, 32'h0);
    if (!pend_valid && beats_left > 0 && pct() >= gap_pct) begin
      pend_valid = 1'b1;
      pend_data  = next_rand();
      pend_strb  = strb_t'(next_rand());
      beats_left--;
    end
    clear_i     = 1'b0;
    len_i       = len_t'(cur_len);
    in_valid_i  = pend_valid;
    in_data_i   = pend_data;  // Held while stalled
    in_strb_i   = pend_strb;
    out_ready_i = (pct() >= bp_pct);
    // Beats that move on the coming rising edge
    if (pend_valid && in_ready_o) begin
      model_accept(pend_data, pend_strb);
      pend_valid = 1'b0;
    end
    if (out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        report_failure("Block sum appeared with no complete block sent");
      end else begin
        exp_sum = exp_q.pop_front();
        check_value("out_data_o", out_data_o, exp_sum);
        check_value("out_strb_o", 32'(out_strb_o), 32'hF);
      end
    end
  endtask

  // Run until every word is taken and every sum has left
  task automatic drain(input int gap_pct, input int bp_pct);
    int cycles;
    cycles = 0;
    while (beats_left > 0 || pend_valid || exp_q.size() > 0) begin
      do_cycle(gap_pct, bp_pct);
      cycles++;
      if (cycles > 4000) report_failure("Stream did not drain before the timeout");
    end
  endtask

  task automatic run_blocks(input int len, input int nblocks, input int gap_pct,
                            input int bp_pct);
    cur_len    = len;  // Pipeline is empty here
    beats_left = len * nblocks;
    drain(gap_pct, bp_pct);
  endtask

  task automatic wait_reset();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > 40) report_failure("Reset was never released");
    end
    @(negedge clk);
  endtask

  task automatic check_idle_flags();
    check_value("out_valid_o", 32'(out_valid_o), 32'h0);
    check_value("in_empty_o", 32'(in_empty_o), 32'h1);
    check_value("out_empty_o", 32'(out_empty_o), 32'h1);
    check_value("in_full_o", 32'(in_full_o), 32'h0);
    check_value("out_full_o", 32'(out_full_o), 32'h0);
  endtask

  // Output stalled until the input FIFO backs up and then released
  task automatic fill_until_full();
    int cycles;
    cur_len    = 1;
    beats_left = 24;  // More than all buffering together
    cycles     = 0;
    while (!in_full_o) begin
      do_cycle(0, 100);
      cycles++;
      if (cycles > 200) report_failure("Input FIFO never became full under back-pressure");
    end
    repeat (10) do_cycle(0, 100);
    drain(0, 30);
  endtask

  // Clear with a sum waiting at the output and a block half taken
  task automatic clear_mid_block();
    int cycles;
    cur_len    = 7;
    beats_left = 11;  // One full block and four words of the next
    cycles     = 0;
    while (beats_left > 0 || pend_valid) begin
      do_cycle(0, 100);
      cycles++;
      if (cycles > 100) report_failure("Partial block was not accepted in time");
    end
    @(negedge clk);
    // Both FIFOs hold data before the clear
    check_value("out_valid_o", 32'(out_valid_o), 32'h1);
    check_value("in_empty_o", 32'(in_empty_o), 32'h0);
    clear_i     = 1'b1;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    acc_q.delete();  // Partial sum is lost
    exp_q.delete();  // Queued sum is flushed too
    @(negedge clk);
    clear_i = 1'b0;
    check_idle_flags();
    run_blocks(5, 3, 20, 20);  // Must sum from zero again
  endtask

  initial begin
    clear_i     = 1'b0;
    len_i       = len_t'(1);
    in_data_i   = '0;
    in_strb_i   = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    wait_reset();
    check_idle_flags();
    check_value("in_ready_o", 32'(in_ready_o), 32'h1);
    // Free output and back to back words
    for (int g = 0; g < 8; g++) run_blocks(1 + pct() % 12, 4, 0, 0);
    // Input gaps and output back-pressure
    for (int g = 0; g < 8; g++) run_blocks(1 + pct() % 12, 3, 35, 45);
    fill_until_full();
    clear_mid_block();
    repeat (20) do_cycle(0, 0);  // Nothing extra may appear
    $display("All checks passed");
    $finish;
  end

endmodule

// File: dv/tb_clock_gen.sv
// ##########################################################
// Testbench clock and reset generator
// 20 ns clock, active-low reset held for 16 cycles
// ##########################################################

module tb_clock_gen #(
  parameter int unsigned RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;  // Half of the 20 ns period
  end

  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);  // Release away from the active edge
    rst_no = 1'b1;
  end

endmodule

// File: logic/accum_engine_top.sv
// ##########################################################
// Top level of the stream accumulator engine
// Input FIFO, block accumulator, output FIFO
// Plain stream ports and FIFO status outputs
// ##########################################################

module accum_engine_top
  import hwpe_stream_package::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,      // Synchronous flush of the whole path
  input  len_t  len_i,

  // Input stream
  input  data_t in_data_i,
  input  strb_t in_strb_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,

  // Block sums
  output data_t out_data_o,
  output strb_t out_strb_o,
  output logic  out_valid_o,
  input  logic  out_ready_i,

  output logic  in_empty_o,
  output logic  in_full_o,
  output logic  out_empty_o,
  output logic  out_full_o
);

  flags_fifo_t in_flags;
  flags_fifo_t out_flags;

  hwpe_stream_intf_stream in_stream ();   // Ports to input FIFO
  hwpe_stream_intf_stream acc_in ();      // Input FIFO to accumulator
  hwpe_stream_intf_stream acc_out ();     // Accumulator to output FIFO
  hwpe_stream_intf_stream out_stream ();  // Output FIFO to ports

  assign in_stream.data  = in_data_i;
  assign in_stream.strb  = in_strb_i;
  assign in_stream.valid = in_valid_i;
  assign in_ready_o      = in_stream.ready;

  hwpe_stream_fifo #(
    .FIFO_DEPTH ( IN_FIFO_DEPTH )
  ) i_in_fifo (
    .clk_i   ( clk_i     ),
    .rst_ni  ( rst_ni    ),
    .clear_i ( clear_i   ),
    .flags_o ( in_flags  ),
    .push_i  ( in_stream ),
    .pop_o   ( acc_in    )
  );

  stream_block_accum i_accum (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .clear_i ( clear_i ),
    .len_i   ( len_i   ),
    .in_i    ( acc_in  ),
    .out_o   ( acc_out )
  );

  hwpe_stream_fifo #(
    .FIFO_DEPTH ( OUT_FIFO_DEPTH )
  ) i_out_fifo (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .clear_i ( clear_i    ),
    .flags_o ( out_flags  ),
    .push_i  ( acc_out    ),
    .pop_o   ( out_stream )
  );

  assign out_data_o       = out_stream.data;
  assign out_strb_o       = out_stream.strb;
  assign out_valid_o      = out_stream.valid;
  assign out_stream.ready = out_ready_i;

  // Status for the host
  assign in_empty_o  = in_flags.empty;
  assign in_full_o   = in_flags.full;
  assign out_empty_o = out_flags.empty;
  assign out_full_o  = out_flags.full;

endmodule

// File: logic/hwpe_stream_fifo.sv
// ##########################################################
// Single-clock flip-flop stream FIFO
// Three-state FSM with wrapping push and pop pointers
// Register array holding data and strobes
// Empty, full and almost flags
// ##########################################################

module hwpe_stream_fifo
  import hwpe_stream_package::*;
#(
  parameter int unsigned FIFO_DEPTH = IN_FIFO_DEPTH
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,

  output flags_fifo_t            flags_o,

  hwpe_stream_intf_stream.sink   push_i,
  hwpe_stream_intf_stream.source pop_o
);

  // Pointer width, at least one bit
  localparam int unsigned ADDR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam logic [ADDR_WIDTH:0] DEPTH_CNT = (ADDR_WIDTH+1)'(FIFO_DEPTH);

  typedef logic [ADDR_WIDTH-1:0] ptr_t;

  // Stored beat
  typedef struct packed {
    data_t data;
    strb_t strb;
  } entry_t;

  typedef enum logic [1:0] {
    EMPTY,
    MIDDLE,
    FULL
  } state_e;

  state_e state_q, state_d;

  ptr_t push_ptr_q, push_ptr_d, push_ptr_inc;
  ptr_t pop_ptr_q, pop_ptr_d, pop_ptr_inc;

  logic push_en;  // Beat written this cycle
  logic pop_en;   // Beat read this cycle

  logic [ADDR_WIDTH:0] ptr_diff;
  logic [ADDR_WIDTH:0] fill;  // Entries held, 0 to FIFO_DEPTH

  entry_t mem_q [FIFO_DEPTH];
  entry_t pop_entry;

  // Handshake from state only, so no fall-through
  always_comb begin
    push_i.ready = 1'b0;
    pop_o.valid  = 1'b0;
    unique case (state_q)
      EMPTY: begin
        push_i.ready = 1'b1;
      end
      MIDDLE: begin
        push_i.ready = 1'b1;
        pop_o.valid  = 1'b1;
      end
      FULL: begin
        pop_o.valid  = 1'b1;  // Stall the producer
      end
      default: begin
        push_i.ready = 1'b0;
        pop_o.valid  = 1'b0;
      end
    endcase
  end

  assign push_en = push_i.valid & push_i.ready;
  assign pop_en  = pop_o.valid & pop_o.ready;

  // Wrap at the last slot, depth need not be a power of two
  assign push_ptr_inc = (push_ptr_q == ptr_t'(FIFO_DEPTH - 1)) ? '0 : push_ptr_q + 1'b1;
  assign pop_ptr_inc  = (pop_ptr_q == ptr_t'(FIFO_DEPTH - 1)) ? '0 : pop_ptr_q + 1'b1;

  // Next state and pointers
  always_comb begin
    state_d    = state_q;
    push_ptr_d = push_ptr_q;
    pop_ptr_d  = pop_ptr_q;
    if (push_en) begin
      push_ptr_d = push_ptr_inc;
    end
    if (pop_en) begin
      pop_ptr_d = pop_ptr_inc;
    end
    unique case ({push_en, pop_en})
      2'b10: begin
        // Push catches up with pop
        state_d = (push_ptr_inc == pop_ptr_q) ? FULL : MIDDLE;
      end
      2'b01: begin
        state_d = (pop_ptr_inc == push_ptr_q) ? EMPTY : MIDDLE;  // Last entry leaves
      end
      default: begin
        state_d = state_q;  // Fill level unchanged
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= EMPTY;
      push_ptr_q <= '0;
      pop_ptr_q  <= '0;
    end else if (clear_i) begin
      state_q    <= EMPTY;  // Drop all entries
      push_ptr_q <= '0;
      pop_ptr_q  <= '0;
    end else begin
      state_q    <= state_d;
      push_ptr_q <= push_ptr_d;
      pop_ptr_q  <= pop_ptr_d;
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[push_ptr_q] <= '{data: push_i.data, strb: push_i.strb};
    end
  end

  // Pointer distance, modulo the depth
  assign ptr_diff = {1'b0, push_ptr_q} - {1'b0, pop_ptr_q};

  always_comb begin
    if (state_q == FULL) begin
      fill = DEPTH_CNT;  // Pointers equal when full
    end else if (push_ptr_q >= pop_ptr_q) begin
      fill = ptr_diff;
    end else begin
      fill = ptr_diff + DEPTH_CNT;  // Push pointer has wrapped
    end
  end

  assign flags_o.empty        = (state_q == EMPTY);
  assign flags_o.full         = (state_q == FULL);
  assign flags_o.almost_empty = (state_q == MIDDLE) && (fill == (ADDR_WIDTH+1)'(1));
  assign flags_o.almost_full  = (state_q == MIDDLE) && (fill == DEPTH_CNT - 1'b1);

  // Head of queue, zero while nothing is offered
  assign pop_entry  = mem_q[pop_ptr_q];
  assign pop_o.data = pop_o.valid ? pop_entry.data : '0;
  assign pop_o.strb = pop_o.valid ? pop_entry.strb : '0;

endmodule

// File: logic/hwpe_stream_intf_stream.sv
// ##########################################################
// Valid/ready stream interface
// Word with byte strobes plus handshake
// Source and sink modports
// ##########################################################

interface hwpe_stream_intf_stream
  import hwpe_stream_package::*;
();

  data_t data;   // Payload word
  strb_t strb;   // Byte enables of data
  logic  valid;  // Source offers a beat
  logic  ready;  // Sink takes it

  // Beat moves on a rising edge with valid and ready high
  // Source keeps data and strb steady while stalled
  modport source (
    output data, strb, valid,
    input  ready
  );

  modport sink (
    input  data, strb, valid,
    output ready
  );

endinterface

// File: logic/hwpe_stream_package.sv
// ##########################################################
// Shared definitions of the stream accumulator engine
// Stream width, strobe width and FIFO depths
// Word, strobe and block length vector types
// FIFO status flag struct
// ##########################################################

package hwpe_stream_package;

  localparam int unsigned DATA_WIDTH     = 32;              // Stream word width
  localparam int unsigned STRB_WIDTH     = DATA_WIDTH / 8;  // One strobe per byte
  localparam int unsigned IN_FIFO_DEPTH  = 8;               // Absorbs input bursts
  localparam int unsigned OUT_FIFO_DEPTH = 2;               // Few results in flight
  localparam int unsigned LEN_WIDTH      = 8;

  // Stream word or block sum
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [STRB_WIDTH-1:0] strb_t;  // Byte enables

  // Words per block
  // Zero selects 256 words since the beat counter wraps
  typedef logic [LEN_WIDTH-1:0] len_t;

  typedef struct packed {
    logic empty;
    logic full;
    logic almost_empty;  // Exactly one entry stored
    logic almost_full;   // Exactly one slot free
  } flags_fifo_t;

endpackage

// File: logic/stream_block_accum.sv
// ##########################################################
// Block accumulator for the stream engine
// Strobe-masked running sum over len_i words
// Beat counter and single result register
// ##########################################################

module stream_block_accum
  import hwpe_stream_package::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  len_t                   len_i,    // Stable within a block

  hwpe_stream_intf_stream.sink   in_i,
  hwpe_stream_intf_stream.source out_o
);

  data_t masked;       // Input word with disabled bytes zeroed
  data_t sum_q;        // Partial block sum
  data_t sum_next;
  data_t res_q;        // Finished block sum
  logic  res_valid_q;  // Result waiting for the sink

  len_t  cnt_q;        // Words taken in current block
  len_t  cnt_last;     // Index of the final word

  logic  in_fire;
  logic  out_fire;
  logic  block_end;    // Last word of block accepted

  // Byte masking
  always_comb begin
    for (int b = 0; b < STRB_WIDTH; b++) begin
      masked[8*b +: 8] = in_i.strb[b] ? in_i.data[8*b +: 8] : 8'h00;
    end
  end

  assign sum_next = sum_q + masked;   // Wraps at 32 bits
  assign cnt_last = len_i - 1'b1;     // Length 0 gives 255, i.e. 256 words

  // Input stalls while a result is pending
  assign in_i.ready = ~res_valid_q;
  assign in_fire    = in_i.valid & in_i.ready;
  assign block_end  = in_fire && (cnt_q == cnt_last);

  assign out_o.valid = res_valid_q;
  assign out_o.data  = res_q;
  assign out_o.strb  = '1;            // Sum is always a full word
  assign out_fire    = out_o.valid & out_o.ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sum_q       <= '0;
      cnt_q       <= '0;
      res_valid_q <= 1'b0;
    end else if (clear_i) begin
      // Partial block and pending result are lost
      sum_q       <= '0;
      cnt_q       <= '0;
      res_valid_q <= 1'b0;
    end else begin
      if (out_fire) begin
        res_valid_q <= 1'b0;
      end
      if (block_end) begin
        sum_q       <= '0;    // Next block starts from zero
        cnt_q       <= '0;
        res_valid_q <= 1'b1;  // Never coincides with out_fire
      end else if (in_fire) begin
        sum_q <= sum_next;
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Result payload
  always_ff @(posedge clk_i) begin
    if (block_end) begin
      res_q <= sum_next;
    end
  end

endmodule

// File: src.f
logic/hwpe_stream_package.sv
logic/hwpe_stream_intf_stream.sv
logic/hwpe_stream_fifo.sv
logic/stream_block_accum.sv
logic/accum_engine_top.sv
dv/tb_clock_gen.sv
dv/tb_accum_engine.sv
